// File: common/tcdm_defines.svh
// global sizing macros for the tcdm subsystem
// bank count, bank index, word index, data and latency widths

`ifndef TCDM_DEFINES_SVH
`define TCDM_DEFINES_SVH

// number of word-interleaved banks
`define TCDM_NUM_BANKS 4

// bank index width, low address bits
`define TCDM_BANK_SEL_W 2

// word index inside one bank
`define TCDM_WORD_IDX_W 4

// data word width
`define TCDM_DATA_W 32

// per-bank latency field width
`define TCDM_LAT_W 3

`endif

// File: common/tcdm_pkg.sv
// shared types for the tcdm subsystem
// width typedefs, request/response structs, bank controller states

`include "tcdm_defines.svh"

package tcdm_pkg;

  //////////////////////////////////////////////////////////////////////
  // plain vector types
  //////////////////////////////////////////////////////////////////////

  // which bank a word lives in
  typedef logic [`TCDM_BANK_SEL_W-1:0] bank_sel_t;

  // word offset inside a bank
  typedef logic [`TCDM_WORD_IDX_W-1:0] word_idx_t;

  // master word address
  // upper bits pick the word, lower bits pick the bank
  typedef logic [`TCDM_WORD_IDX_W+`TCDM_BANK_SEL_W-1:0] addr_t;

  // one data word
  typedef logic [`TCDM_DATA_W-1:0] data_t;

  // extra wait cycles of a bank
  typedef logic [`TCDM_LAT_W-1:0] lat_t;

  //////////////////////////////////////////////////////////////////////
  // payload structs
  //////////////////////////////////////////////////////////////////////

  // master request payload
  typedef struct packed {
    logic  we;
    addr_t addr;
    data_t wdata;
  } tcdm_req_t;

  // bank response payload, zero for writes
  typedef struct packed {
    data_t rdata;
  } tcdm_resp_t;

  // bank controller states
  typedef enum logic [1:0] {
    IDLE,
    WAIT,
    RESP
  } bank_state_e;

endpackage

// File: bank/bank_lat_timer.sv
// bank latency timer
// loadable down-counter, flags zero when not loading

`timescale 1ns/10ps

module bank_lat_timer
  import tcdm_pkg::*;
(
  input  logic clk_i,
  input  logic rst_ni,
  // start a new wait
  input  logic load_i,
  input  lat_t lat_i,
  output logic expired_o
);

  lat_t cnt_q;

  // a load this cycle hides the old zero
  assign expired_o = (cnt_q == '0) & ~load_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (load_i) begin
      cnt_q <= lat_i;
    end else if (cnt_q != '0) begin
      // count down, then sit at zero
      cnt_q <= cnt_q - 1'b1;
    end
  end

endmodule

// File: bank/bank_ctrl.sv
// bank controller FSM
// grants in idle, waits on the latency timer, pulses the valid

`timescale 1ns/10ps

module bank_ctrl
  import tcdm_pkg::*;
(
  input  logic clk_i,
  input  logic rst_ni,
  // request from the decoder
  input  logic req_i,
  // latency timer done
  input  logic expired_i,
  output logic gnt_o,
  // loads storage and timer
  output logic accept_o,
  output logic vld_o
);

  bank_state_e state_d;
  bank_state_e state_q;

  //////////////////////////////////////////////////////////////////////
  // outputs
  //////////////////////////////////////////////////////////////////////

  // ready for a new access only when idle
  assign gnt_o    = (state_q == IDLE);
  assign accept_o = gnt_o & req_i;

  // response valid for the single RESP cycle
  assign vld_o    = (state_q == RESP);

  //////////////////////////////////////////////////////////////////////
  // next state
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE: begin
        // access happens on this edge, then wait out the latency
        if (accept_o) begin
          state_d = WAIT;
        end
      end
      WAIT: begin
        // zero latency passes through here once
        if (expired_i) begin
          state_d = RESP;
        end
      end
      RESP: begin
        // one valid cycle, then free again
        state_d = IDLE;
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // state register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

// File: bank/tcdm_bank.sv
// one tcdm bank
// storage array, response register, controller and latency timer

`timescale 1ns/10ps

`include "tcdm_defines.svh"

module tcdm_bank
  import tcdm_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       req_i,
  input  tcdm_req_t  req_data_i,
  // wait cycles before answering
  input  lat_t       lat_i,
  output logic       gnt_o,
  output logic       vld_o,
  output tcdm_resp_t resp_o
);

  localparam int unsigned NumWords = 1 << `TCDM_WORD_IDX_W;

  data_t      mem_q [NumWords];
  tcdm_resp_t resp_q;
  word_idx_t  word_idx;

  // accepted request, pulses at the accepting edge
  logic accept;
  // timer reached zero
  logic expired;

  // word index sits above the bank bits
  assign word_idx = req_data_i.addr[`TCDM_BANK_SEL_W +: `TCDM_WORD_IDX_W];

  //////////////////////////////////////////////////////////////////////
  // control
  //////////////////////////////////////////////////////////////////////

  bank_ctrl bank_ctrl_inst (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .req_i     (req_i),
    .expired_i (expired),
    .gnt_o     (gnt_o),
    .accept_o  (accept),
    .vld_o     (vld_o)
  );

  // latency counted from the same edge as the access
  bank_lat_timer bank_lat_timer_inst (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .load_i    (accept),
    .lat_i     (lat_i),
    .expired_o (expired)
  );

  //////////////////////////////////////////////////////////////////////
  // storage
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (accept) begin
      if (req_data_i.we) begin
        mem_q[word_idx] <= req_data_i.wdata;
        // writes answer with zero data
        resp_q.rdata    <= '0;
      end else begin
        resp_q.rdata    <= mem_q[word_idx];
      end
    end
  end

  // held until the next accepted request
  assign resp_o = resp_q;

endmodule

// File: logic/addr_dec_resp_mux_varlat.sv
// bank address decoder and response mux
// allows a single transaction in flight, variable bank latency

`timescale 1ns/10ps

`include "tcdm_defines.svh"

module addr_dec_resp_mux_varlat
  import tcdm_pkg::*;
(
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  // master side
  input  logic                                 req_i,
  input  tcdm_req_t                            data_i,
  output logic                                 gnt_o,
  output logic                                 vld_o,
  output tcdm_resp_t                           rdata_o,
  // bank side
  output logic      [`TCDM_NUM_BANKS-1:0]      req_o,
  input  logic      [`TCDM_NUM_BANKS-1:0]      gnt_i,
  input  logic      [`TCDM_NUM_BANKS-1:0]      vld_i,
  output tcdm_req_t [`TCDM_NUM_BANKS-1:0]      data_o,
  input  tcdm_resp_t [`TCDM_NUM_BANKS-1:0]     rdata_i
);

  // bank addressed by the current master request
  bank_sel_t bank_sel;
  // bank of the transaction in flight
  bank_sel_t bank_sel_q;

  logic inflight_d;
  logic inflight_q;

  // port free this cycle
  logic fwd;
  // master request accepted this cycle
  logic accept;

  //////////////////////////////////////////////////////////////////////
  // request side
  //////////////////////////////////////////////////////////////////////

  // low address bits select the bank
  assign bank_sel = data_i.addr[`TCDM_BANK_SEL_W-1:0];

  // free when idle, or when the pending response lands now
  assign fwd = ~inflight_q | vld_o;

  // grant only from the addressed bank, and only while free
  assign gnt_o  = gnt_i[bank_sel] & fwd;
  assign accept = req_i & gnt_o;

  // one-hot request toward the addressed bank
  always_comb begin
    req_o = '0;
    if (fwd) begin
      req_o[bank_sel] = req_i;
    end
  end

  // payload goes to every bank, only the requested one samples it
  assign data_o = {`TCDM_NUM_BANKS{data_i}};

  //////////////////////////////////////////////////////////////////////
  // in-flight tracking
  //////////////////////////////////////////////////////////////////////

  // new acceptance wins over the arriving valid
  always_comb begin
    inflight_d = inflight_q;
    if (accept) begin
      inflight_d = 1'b1;
    end else if (vld_o) begin
      inflight_d = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      inflight_q <= 1'b0;
      bank_sel_q <= '0;
    end else begin
      inflight_q <= inflight_d;
      // remember where the response will come from
      if (accept) begin
        bank_sel_q <= bank_sel;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // response side
  //////////////////////////////////////////////////////////////////////

  // steer the pending bank back, no extra register stage
  assign rdata_o = rdata_i[bank_sel_q];
  // ignore any valid that does not belong to us
  assign vld_o   = vld_i[bank_sel_q] & inflight_q;

endmodule

// File: logic/tcdm_varlat_top.sv
// tcdm subsystem top level
// decoder in front of four variable-latency banks

`timescale 1ns/10ps

`include "tcdm_defines.svh"

module tcdm_varlat_top
  import tcdm_pkg::*;
(
  input  logic                         clk_i,
  input  logic                         rst_ni,
  // master port
  input  logic                         req_i,
  input  tcdm_req_t                    req_data_i,
  // per-bank latency config, held stable outside
  input  lat_t [`TCDM_NUM_BANKS-1:0]   bank_lat_i,
  output logic                         gnt_o,
  output logic                         vld_o,
  output tcdm_resp_t                   resp_o
);

  // decoder to bank wiring
  logic       [`TCDM_NUM_BANKS-1:0] bank_req;
  logic       [`TCDM_NUM_BANKS-1:0] bank_gnt;
  logic       [`TCDM_NUM_BANKS-1:0] bank_vld;
  tcdm_req_t  [`TCDM_NUM_BANKS-1:0] bank_data;
  tcdm_resp_t [`TCDM_NUM_BANKS-1:0] bank_resp;

  //////////////////////////////////////////////////////////////////////
  // decoder and response mux
  //////////////////////////////////////////////////////////////////////

  addr_dec_resp_mux_varlat addr_dec_resp_mux_varlat_inst (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .req_i   (req_i),
    .data_i  (req_data_i),
    .gnt_o   (gnt_o),
    .vld_o   (vld_o),
    .rdata_o (resp_o),
    .req_o   (bank_req),
    .gnt_i   (bank_gnt),
    .vld_i   (bank_vld),
    .data_o  (bank_data),
    .rdata_i (bank_resp)
  );

  //////////////////////////////////////////////////////////////////////
  // banks
  //////////////////////////////////////////////////////////////////////

  // each bank sees its own latency entry
  for (genvar b = 0; b < `TCDM_NUM_BANKS; b++) begin : gen_bank
    tcdm_bank tcdm_bank_inst (
      .clk_i      (clk_i),
      .rst_ni     (rst_ni),
      .req_i      (bank_req[b]),
      .req_data_i (bank_data[b]),
      .lat_i      (bank_lat_i[b]),
      .gnt_o      (bank_gnt[b]),
      .vld_o      (bank_vld[b]),
      .resp_o     (bank_resp[b])
    );
  end

endmodule

// File: verif/tb_clk_gen.sv
// testbench clock and reset source
// free-running clock, active-low reset held for a few cycles

`timescale 1ns/10ps

module tb_clk_gen #(
  parameter int unsigned PeriodNs    = 20,
  parameter int unsigned ResetCycles = 5
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2) clk_o = ~clk_o;
  end

  // release on a falling edge, away from the flops
  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

// File: verif/tb_tcdm_varlat.sv
// testbench for the tcdm variable-latency subsystem
// stimulus tasks, reference memory and response model, comparing monitor

`timescale 1ns/10ps

`include "tcdm_defines.svh"

module tb_tcdm_varlat
  import tcdm_pkg::*;
();

  localparam int unsigned TimeoutCycles = 64;
  localparam int unsigned NumAddr       = 1 << (`TCDM_WORD_IDX_W + `TCDM_BANK_SEL_W);

  // expected outcome of one accepted transfer
  typedef struct packed {
    logic [31:0] vld_edge;
    bank_sel_t   bank;
    data_t       rdata;
  } expect_t;

  logic                        clk_i;
  logic                        rst_ni;
  logic                        req_i;
  tcdm_req_t                   req_data_i;
  lat_t [`TCDM_NUM_BANKS-1:0]  bank_lat_i;
  logic                        gnt_o;
  logic                        vld_o;
  tcdm_resp_t                  resp_o;

  // reference state kept by the monitor
  data_t       ref_mem [NumAddr];
  expect_t     pend_exp;
  logic        pending          = 1'b0;
  logic [31:0] edge_cnt         = '0;
  logic [31:0] last_accept_edge = '0;
  logic [31:0] last_vld_edge    = '0;

  int unsigned mismatch_errs = 0;
  int unsigned timeout_errs  = 0;
  int unsigned protocol_errs = 0;
  int unsigned n_checked     = 0;
  integer      seed          = 32'hec7f6627;
  string       test_name     = "reset";

  tb_clk_gen #(.PeriodNs(20), .ResetCycles(5)) tb_clk_gen_inst (
    .clk_o  (clk_i),
    .rst_no (rst_ni)
  );

  tcdm_varlat_top tcdm_varlat_top_inst (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req_i      (req_i),
    .req_data_i (req_data_i),
    .bank_lat_i (bank_lat_i),
    .gnt_o      (gnt_o),
    .vld_o      (vld_o),
    .resp_o     (resp_o)
  );

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  function automatic expect_t predict_resp(input tcdm_req_t req, input lat_t lat,
                                           input logic [31:0] accept_edge);
    expect_t e;
    // valid rises lat+1 cycles after acceptance and is sampled one edge later
    e.vld_edge = accept_edge + 32'(lat) + 32'd2;
    e.bank     = req.addr[`TCDM_BANK_SEL_W-1:0];
    // writes answer with zero
    e.rdata    = req.we ? '0 : ref_mem[req.addr];
    return e;
  endfunction

  // fill word built from every address bit
  function automatic data_t fill_word(input addr_t a);
    return {a, 2'b10, ~a, 2'b01, a, 4'hc, ~a};
  endfunction

  //////////////////////////////////////////////////////////////////////
  // comparing monitor sampling on the rising edge
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    logic      exp_gnt;
    logic      vld_due;
    bank_sel_t req_bank;
    if (rst_ni) begin
      req_bank = req_data_i.addr[`TCDM_BANK_SEL_W-1:0];
      vld_due  = pending && (edge_cnt == pend_exp.vld_edge);
      // port free when idle or in the valid cycle of another bank
      exp_gnt  = !pending || (vld_due && (req_bank != pend_exp.bank));
      assert (gnt_o === exp_gnt) else begin
        $display("mismatch %s: gnt_o at edge %0d expected %b, actual %b",
                 test_name, edge_cnt, exp_gnt, gnt_o);
        mismatch_errs++;
      end
      if (vld_due) begin
        assert (vld_o === 1'b1) else begin
          $display("mismatch %s: vld_o at edge %0d expected %b, actual %b",
                   test_name, edge_cnt, 1'b1, vld_o);
          mismatch_errs++;
        end
        assert (resp_o.rdata === pend_exp.rdata) else begin
          $display("mismatch %s: resp_o expected %h, actual %h",
                   test_name, pend_exp.rdata, resp_o.rdata);
          mismatch_errs++;
        end
        pending       = 1'b0;
        last_vld_edge = edge_cnt;
        n_checked++;
      end else begin
        assert (vld_o === 1'b0) else begin
          $display("mismatch %s: vld_o at edge %0d expected %b, actual %b",
                   test_name, edge_cnt, 1'b0, vld_o);
          mismatch_errs++;
        end
      end
      // acceptance may share its edge with the valid
      if (req_i && gnt_o) begin
        assert (!pending) else begin
          $display("%s: a second request was accepted while one was in flight",
                   test_name);
          protocol_errs++;
        end
        pend_exp         = predict_resp(req_data_i, bank_lat_i[req_bank], edge_cnt);
        pending          = 1'b1;
        last_accept_edge = edge_cnt;
        if (req_data_i.we) begin
          ref_mem[req_data_i.addr] = req_data_i.wdata;
        end
      end
      edge_cnt++;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus tasks called on the falling edge
  //////////////////////////////////////////////////////////////////////

  // hold the request until granted and then drop it
  task automatic transfer(input logic we, input addr_t addr, input data_t wdata);
    logic        granted;
    int unsigned n;
    granted    = 1'b0;
    n          = 0;
    req_i      = 1'b1;
    req_data_i = '{we: we, addr: addr, wdata: wdata};
    while (!granted && n < TimeoutCycles) begin
      @(posedge clk_i);
      granted = gnt_o;
      n++;
    end
    assert (granted) else begin
      $display("%s: request to address %0d was never granted", test_name, addr);
      timeout_errs++;
    end
    @(negedge clk_i);
    req_i = 1'b0;
  endtask

  task automatic wait_idle();
    int unsigned n;
    n = 0;
    while (pending && n < TimeoutCycles) begin
      @(negedge clk_i);
      n++;
    end
    assert (!pending) else begin
      $display("%s: no response arrived within %0d cycles", test_name, n);
      timeout_errs++;
    end
  endtask

  // latencies only change with nothing in flight
  task automatic randomize_lat();
    integer r;
    wait_idle();
    for (int b = 0; b < `TCDM_NUM_BANKS; b++) begin
      r             = $random(seed);
      bank_lat_i[b] = lat_t'(r);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int unsigned n;
    integer      r;
    addr_t       a;
    req_i      = 1'b0;
    req_data_i = '0;
    bank_lat_i = '0;

    // reset state
    n = 0;
    while (rst_ni !== 1'b1 && n < TimeoutCycles) begin
      @(posedge clk_i);
      assert (vld_o === 1'b0) else begin
        $display("mismatch %s: vld_o expected %b, actual %b", test_name, 1'b0, vld_o);
        mismatch_errs++;
      end
      n++;
    end
    assert (rst_ni === 1'b1) else begin
      $display("%s: reset was never released", test_name);
      timeout_errs++;
    end
    @(negedge clk_i);
    for (int i = 0; i < 3; i++) begin
      assert (gnt_o === 1'b1) else begin
        $display("mismatch %s: gnt_o expected %b, actual %b", test_name, 1'b1, gnt_o);
        mismatch_errs++;
      end
      @(negedge clk_i);
    end

    // fill every word and then read back in reverse
    test_name = "write_read";
    bank_lat_i = {lat_t'(3), lat_t'(0), lat_t'(2), lat_t'(1)};
    for (int i = 0; i < NumAddr; i++) begin
      transfer(1'b1, addr_t'(i), fill_word(addr_t'(i)));
    end
    for (int i = NumAddr - 1; i >= 0; i--) begin
      transfer(1'b0, addr_t'(i), '0);
    end
    wait_idle();

    // one isolated read per bank with the first round at the extremes
    test_name = "latency";
    bank_lat_i = {lat_t'(5), lat_t'(3), lat_t'(7), lat_t'(0)};
    for (int round = 0; round < 4; round++) begin
      if (round != 0) begin
        randomize_lat();
      end
      for (int b = 0; b < `TCDM_NUM_BANKS; b++) begin
        r = $random(seed);
        transfer(1'b0, {word_idx_t'(r), bank_sel_t'(b)}, '0);
        wait_idle();
      end
    end

    // held request to another bank lands in the valid cycle
    test_name = "single_in_flight";
    bank_lat_i = {lat_t'(2), lat_t'(1), lat_t'(0), lat_t'(5)};
    transfer(1'b0, addr_t'(0), '0);
    transfer(1'b0, addr_t'(5), '0);
    assert (last_accept_edge == last_vld_edge) else begin
      $display("mismatch %s: accept edge expected %0d, actual %0d",
               test_name, last_vld_edge, last_accept_edge);
      mismatch_errs++;
    end
    wait_idle();
    // same bank waits one more cycle for IDLE
    transfer(1'b0, addr_t'(4), '0);
    transfer(1'b1, addr_t'(8), 32'h600d_f00d);
    assert (last_accept_edge == last_vld_edge + 32'd1) else begin
      $display("mismatch %s: accept edge expected %0d, actual %0d",
               test_name, last_vld_edge + 32'd1, last_accept_edge);
      mismatch_errs++;
    end
    wait_idle();

    // mixed traffic with occasional latency changes
    test_name = "random_traffic";
    for (int i = 0; i < 300; i++) begin
      r = $random(seed);
      if (r[1:0] == 2'b00) begin
        randomize_lat();
      end
      a = addr_t'(r >> 4);
      transfer(r[2], a, $random(seed));
    end
    wait_idle();

    $display("errors: mismatch %0d, timeout %0d, protocol %0d; responses checked %0d",
             mismatch_errs, timeout_errs, protocol_errs, n_checked);
    if (mismatch_errs + timeout_errs + protocol_errs == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: filelist.f
+incdir+common
common/tcdm_pkg.sv
bank/bank_lat_timer.sv
bank/bank_ctrl.sv
bank/tcdm_bank.sv
logic/addr_dec_resp_mux_varlat.sv
logic/tcdm_varlat_top.sv
verif/tb_clk_gen.sv
verif/tb_tcdm_varlat.sv

// File: Bender.yml
package:
  name: tcdm_varlat

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/tcdm_pkg.sv
      - bank/bank_lat_timer.sv
      - bank/bank_ctrl.sv
      - bank/tcdm_bank.sv
      - logic/addr_dec_resp_mux_varlat.sv
      - logic/tcdm_varlat_top.sv

  - target: test
    include_dirs:
      - common
    files:
      - verif/tb_clk_gen.sv
      - verif/tb_tcdm_varlat.sv
